// File: rtl/conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

//////////////////////////////////////////////////
// Layer geometry
//////////////////////////////////////////////////

// Input image size in pixels
`define CONV_IMG_W 6
`define CONV_IMG_H 6

// Channel counts
`define CONV_CH_IN  2
`define CONV_CH_OUT 2

// Square kernel, rate 1, no padding
`define CONV_KERNEL 3

// Valid convolution output size
`define CONV_OUT_W      (`CONV_IMG_W - `CONV_KERNEL + 1)
`define CONV_OUT_PIXELS (`CONV_OUT_W * (`CONV_IMG_H - `CONV_KERNEL + 1))

//////////////////////////////////////////////////
// Output side
//////////////////////////////////////////////////

`define CONV_QUEUE_DEPTH 32
`define CONV_OUT_CREDITS 4

`endif

// File: rtl/conv_pkg.sv
`default_nettype none

package conv_pkg;

  // Signed input pixel
  typedef logic signed [7:0] pix_t;

  // Signed kernel weight
  typedef logic signed [7:0] wgt_t;

  // Full precision sum, never rounded or saturated
  typedef logic signed [23:0] acc_t;

  // Loop reader FSM
  typedef enum logic [1:0] {
    RD_LOAD,
    RD_WAIT_ROOM,
    RD_REPLAY
  } reader_state_e;

endpackage

`default_nettype wire

// File: rtl/conv_loop_reader.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv_consts.svh"

module conv_loop_reader import conv_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic pxl_valid,
  input  pix_t pxl_in,
  input  logic plane_room,
  output logic in_ready,
  output logic loop_valid,
  output pix_t loop_pxl,
  output logic loop_ic,
  output logic loop_oc
);

  localparam int PLANE  = `CONV_IMG_W * `CONV_IMG_H;
  localparam int FRAME  = PLANE * `CONV_CH_IN;
  localparam int ADDR_W = $clog2(FRAME);
  localparam int POS_W  = $clog2(PLANE);

  // A single input channel means every plane is the last one
  localparam reader_state_e FIRST_STATE = (`CONV_CH_IN == 1) ? RD_WAIT_ROOM : RD_REPLAY;

  reader_state_e     state;
  pix_t              frame_mem [FRAME];
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;
  logic [POS_W-1:0]  rd_pos;
  logic              rd_ic;
  logic              rd_oc;
  logic              plane_end;
  logic              ic_last;
  logic              oc_last;
  logic              next_ic_last;

  assign in_ready     = (state == RD_LOAD);
  assign rd_addr      = ADDR_W'(int'(rd_ic) * PLANE + int'(rd_pos));
  assign plane_end    = (rd_pos == POS_W'(PLANE - 1));
  assign ic_last      = (int'(rd_ic) == `CONV_CH_IN - 1);
  assign oc_last      = (int'(rd_oc) == `CONV_CH_OUT - 1);
  assign next_ic_last = (int'(rd_ic) + 1 == `CONV_CH_IN - 1);

  //////////////////////////////////////////////////
  // Load and replay FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= RD_LOAD;
      wr_addr    <= '0;
      rd_pos     <= '0;
      rd_ic      <= 1'b0;
      rd_oc      <= 1'b0;
      loop_valid <= 1'b0;
    end else begin
      loop_valid <= 1'b0;
      case (state)
        RD_LOAD: begin
          if (pxl_valid) begin
            if (wr_addr == ADDR_W'(FRAME - 1)) begin
              wr_addr <= '0;
              state   <= FIRST_STATE;
            end else begin
              wr_addr <= wr_addr + 1'b1;
            end
          end
        end
        // Only the last plane writes the queue, so room is checked here
        RD_WAIT_ROOM: begin
          if (plane_room) begin
            state <= RD_REPLAY;
          end
        end
        RD_REPLAY: begin
          loop_valid <= 1'b1;
          if (plane_end) begin
            rd_pos <= '0;
            if (ic_last) begin
              rd_ic <= 1'b0;
              if (oc_last) begin
                rd_oc <= 1'b0;
                state <= RD_LOAD;
              end else begin
                rd_oc <= rd_oc + 1'b1;
                state <= FIRST_STATE;
              end
            end else begin
              rd_ic <= rd_ic + 1'b1;
              if (next_ic_last) begin
                state <= RD_WAIT_ROOM;
              end
            end
          end else begin
            rd_pos <= rd_pos + 1'b1;
          end
        end
        default: state <= RD_LOAD;
      endcase
    end
  end

  // Frame store and tagged replay data
  always_ff @(posedge clk) begin
    if (in_ready && pxl_valid) begin
      frame_mem[wr_addr] <= pxl_in;
    end
    loop_pxl <= frame_mem[rd_addr];
    loop_ic  <= rd_ic;
    loop_oc  <= rd_oc;
  end

endmodule

`default_nettype wire

// File: rtl/conv_window_engine.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv_consts.svh"

module conv_window_engine import conv_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic weight_valid,
  input  wgt_t weight_in,
  input  logic loop_valid,
  input  pix_t loop_pxl,
  input  logic loop_ic,
  input  logic loop_oc,
  output logic conv_valid,
  output acc_t conv_data,
  output logic conv_ic
);

  localparam int K      = `CONV_KERNEL;
  localparam int TAPS   = K * K;
  localparam int N_WGT  = TAPS * `CONV_CH_IN * `CONV_CH_OUT;
  localparam int WIDX_W = $clog2(N_WGT);
  localparam int COL_W  = $clog2(`CONV_IMG_W);
  localparam int ROW_W  = $clog2(`CONV_IMG_H);
  localparam int PROD_W = $bits(pix_t) + $bits(wgt_t);

  wgt_t                     weight_mem [N_WGT];
  logic [WIDX_W-1:0]        w_idx;
  logic [WIDX_W-1:0]        wgt_base;
  logic [COL_W-1:0]         col;
  logic [ROW_W-1:0]         row;
  pix_t                     line_buf [K-1][`CONV_IMG_W];
  pix_t                     win [K][K];
  pix_t                     col_in [K];
  pix_t                     cur_win [K][K];
  logic                     win_done;
  logic signed [PROD_W-1:0] prod_d [TAPS];
  logic signed [PROD_W-1:0] prod_q [TAPS];
  logic                     valid_s1;
  logic                     ic_s1;
  acc_t                     sum_d;

  //////////////////////////////////////////////////
  // Weight store
  //////////////////////////////////////////////////

  // Load order is oc, ic, kernel row, kernel column
  always_ff @(posedge clk) begin
    if (reset) begin
      w_idx <= '0;
    end else if (weight_valid) begin
      w_idx <= (w_idx == WIDX_W'(N_WGT - 1)) ? '0 : w_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (weight_valid) begin
      weight_mem[w_idx] <= weight_in;
    end
  end

  assign wgt_base = WIDX_W'((int'(loop_oc) * `CONV_CH_IN + int'(loop_ic)) * TAPS);

  //////////////////////////////////////////////////
  // Raster position and window
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      col <= '0;
      row <= '0;
    end else if (loop_valid) begin
      if (col == COL_W'(`CONV_IMG_W - 1)) begin
        col <= '0;
        row <= (row == ROW_W'(`CONV_IMG_H - 1)) ? '0 : row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  assign win_done = loop_valid && (int'(row) >= K - 1) && (int'(col) >= K - 1);

  // Window as it stands once the current pixel is shifted in
  always_comb begin
    for (int r = 0; r < K - 1; r++) begin
      col_in[r] = line_buf[K-2-r][col];
    end
    col_in[K-1] = loop_pxl;
    for (int r = 0; r < K; r++) begin
      for (int c = 0; c < K - 1; c++) begin
        cur_win[r][c] = win[r][c+1];
      end
      cur_win[r][K-1] = col_in[r];
    end
    for (int t = 0; t < TAPS; t++) begin
      prod_d[t] = PROD_W'(cur_win[t/K][t%K]) *
                  PROD_W'(weight_mem[wgt_base + WIDX_W'(t)]);
    end
  end

  // Line buffer 0 holds the previous row
  always_ff @(posedge clk) begin
    if (loop_valid) begin
      line_buf[0][col] <= loop_pxl;
      for (int i = 1; i < K - 1; i++) begin
        line_buf[i][col] <= line_buf[i-1][col];
      end
      win <= cur_win;
    end
  end

  //////////////////////////////////////////////////
  // Multiply then add
  //////////////////////////////////////////////////

  always_comb begin
    sum_d = '0;
    for (int t = 0; t < TAPS; t++) begin
      sum_d = sum_d + acc_t'(prod_q[t]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_s1   <= 1'b0;
      conv_valid <= 1'b0;
    end else begin
      valid_s1   <= win_done;
      conv_valid <= valid_s1;
    end
  end

  always_ff @(posedge clk) begin
    if (win_done) begin
      prod_q <= prod_d;
      ic_s1  <= loop_ic;
    end
    if (valid_s1) begin
      conv_data <= sum_d;
      conv_ic   <= ic_s1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/conv_channel_accumulator.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv_consts.svh"

module conv_channel_accumulator import conv_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic conv_valid,
  input  acc_t conv_data,
  input  logic conv_ic,
  output logic acc_valid,
  output acc_t acc_data
);

  localparam int IDX_W = $clog2(`CONV_OUT_PIXELS);

  acc_t             psum [`CONV_OUT_PIXELS];
  logic [IDX_W-1:0] res_idx;
  logic             last_ic;
  acc_t             total;

  assign last_ic = (int'(conv_ic) == `CONV_CH_IN - 1);

  // Channel 0 starts a fresh sum
  assign total = (conv_ic == 1'b0) ? conv_data : psum[res_idx] + conv_data;

  //////////////////////////////////////////////////
  // Result index and valid
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      res_idx   <= '0;
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= conv_valid && last_ic;
      if (conv_valid) begin
        if (res_idx == IDX_W'(`CONV_OUT_PIXELS - 1)) begin
          res_idx <= '0;
        end else begin
          res_idx <= res_idx + 1'b1;
        end
      end
    end
  end

  // Partial sums stay local until the last channel
  always_ff @(posedge clk) begin
    if (conv_valid) begin
      if (last_ic) begin
        acc_data <= total;
      end else begin
        psum[res_idx] <= total;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/conv_output_queue.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv_consts.svh"

module conv_output_queue import conv_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic acc_valid,
  input  acc_t acc_data,
  input  logic out_credit,
  output logic out_valid,
  output acc_t out_data,
  output logic plane_room
);

  localparam int DEPTH = `CONV_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(`CONV_OUT_CREDITS + 1);

  acc_t             fifo_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] occupancy;
  logic [CRD_W-1:0] credit_cnt;
  logic             full;
  logic             empty;
  logic             wr_en;
  logic             rd_en;

  assign full  = (occupancy == CNT_W'(DEPTH));
  assign empty = (occupancy == '0);
  assign wr_en = acc_valid && !full;

  // The result now on the output still holds one credit
  assign rd_en = !empty && (credit_cnt > CRD_W'(out_valid));

  // Enough space for a whole output plane
  assign plane_room = (occupancy <= CNT_W'(DEPTH - `CONV_OUT_PIXELS));

  //////////////////////////////////////////////////
  // Pointers, occupancy and credits
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      occupancy  <= '0;
      credit_cnt <= CRD_W'(`CONV_OUT_CREDITS);
      out_valid  <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      occupancy  <= occupancy + CNT_W'(wr_en) - CNT_W'(rd_en);
      credit_cnt <= credit_cnt - CRD_W'(out_valid) + CRD_W'(out_credit);
      out_valid  <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      fifo_mem[wr_ptr] <= acc_data;
    end
    if (rd_en) begin
      out_data <= fifo_mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

// File: rtl/conv_layer_top.sv
`timescale 1ns/100ps
`default_nettype none

module conv_layer_top import conv_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic weight_valid,
  input  wgt_t weight_in,
  input  logic pxl_valid,
  input  pix_t pxl_in,
  input  logic out_credit,
  output logic in_ready,
  output logic out_valid,
  output acc_t out_data
);

  logic weight_accept;
  logic loop_valid;
  pix_t loop_pxl;
  logic loop_ic;
  logic loop_oc;
  logic conv_valid;
  acc_t conv_data;
  logic conv_ic;
  logic acc_valid;
  acc_t acc_data;
  logic plane_room;

  // Weights are taken only between frames
  assign weight_accept = weight_valid && in_ready;

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  conv_loop_reader i_loop_reader (
    .clk        (clk),
    .reset      (reset),
    .pxl_valid  (pxl_valid),
    .pxl_in     (pxl_in),
    .plane_room (plane_room),
    .in_ready   (in_ready),
    .loop_valid (loop_valid),
    .loop_pxl   (loop_pxl),
    .loop_ic    (loop_ic),
    .loop_oc    (loop_oc)
  );

  conv_window_engine i_window_engine (
    .clk          (clk),
    .reset        (reset),
    .weight_valid (weight_accept),
    .weight_in    (weight_in),
    .loop_valid   (loop_valid),
    .loop_pxl     (loop_pxl),
    .loop_ic      (loop_ic),
    .loop_oc      (loop_oc),
    .conv_valid   (conv_valid),
    .conv_data    (conv_data),
    .conv_ic      (conv_ic)
  );

  conv_channel_accumulator i_channel_accumulator (
    .clk        (clk),
    .reset      (reset),
    .conv_valid (conv_valid),
    .conv_data  (conv_data),
    .conv_ic    (conv_ic),
    .acc_valid  (acc_valid),
    .acc_data   (acc_data)
  );

  conv_output_queue i_output_queue (
    .clk        (clk),
    .reset      (reset),
    .acc_valid  (acc_valid),
    .acc_data   (acc_data),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .plane_room (plane_room)
  );

endmodule

`default_nettype wire

// File: test/conv_layer_properties.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv_consts.svh"

module conv_layer_properties #(
  parameter int CRD_W = $clog2(`CONV_OUT_CREDITS + 1),
  parameter int CNT_W = $clog2(`CONV_QUEUE_DEPTH + 1)
) (
  input wire logic             clk,
  input wire logic             reset,
  input wire logic             acc_valid,
  input wire logic             full,
  input wire logic             out_valid,
  input wire logic [CNT_W-1:0] occupancy,
  input wire logic [CRD_W-1:0] credit_cnt
);

  //////////////////////////////////////////////////
  // Credit flow control
  //////////////////////////////////////////////////

  credit_gate: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> (credit_cnt != '0))
    else $error("out_valid high with no credit left");

  //////////////////////////////////////////////////
  // FIFO occupancy
  //////////////////////////////////////////////////

  occupancy_bound: assert property (@(posedge clk) disable iff (reset)
    occupancy <= CNT_W'(`CONV_QUEUE_DEPTH))
    else $error("queue occupancy above its depth");

  no_write_when_full: assert property (@(posedge clk) disable iff (reset)
    !(acc_valid && full))
    else $error("result written while the queue is full");

  // Output idle right after reset
  idle_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

endmodule

bind conv_output_queue conv_layer_properties i_queue_properties (
  .clk        (clk),
  .reset      (reset),
  .acc_valid  (acc_valid),
  .full       (full),
  .out_valid  (out_valid),
  .occupancy  (occupancy),
  .credit_cnt (credit_cnt)
);

`default_nettype wire

// File: test/conv_layer_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "conv_consts.svh"

module conv_layer_tb import conv_pkg::*; ();

  localparam int K       = `CONV_KERNEL;
  localparam int PLANE   = `CONV_IMG_W * `CONV_IMG_H;
  localparam int N_PIX   = PLANE * `CONV_CH_IN;
  localparam int N_WGT   = K * K * `CONV_CH_IN * `CONV_CH_OUT;
  localparam int OUT_H   = `CONV_OUT_PIXELS / `CONV_OUT_W;
  localparam int N_RES   = `CONV_OUT_PIXELS * `CONV_CH_OUT;
  localparam int N_ROWS  = 5;
  localparam int TIMEOUT = 2000;

  // Pixel and weight modes
  localparam int PIX_RANDOM = 0;
  localparam int PIX_ONES   = 1;
  localparam int PIX_RAMP   = 2;
  localparam int WGT_RANDOM = 0;
  localparam int WGT_CENTRE = 1;
  localparam int WGT_ONES   = 2;

  logic clk;
  logic reset;
  logic weight_valid;
  wgt_t weight_in;
  logic pxl_valid;
  pix_t pxl_in;
  logic out_credit;
  logic in_ready;
  logic out_valid;
  acc_t out_data;

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  int pix_mode_tab [N_ROWS] = '{PIX_RANDOM, PIX_RAMP, PIX_RANDOM, PIX_ONES, PIX_RANDOM};
  int wgt_mode_tab [N_ROWS] = '{WGT_CENTRE, WGT_ONES, WGT_ONES, WGT_RANDOM, WGT_RANDOM};
  bit reload_tab   [N_ROWS] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
  int delay_tab    [N_ROWS] = '{0, 3, 20, 0, 20};

  pix_t frame [N_PIX];
  wgt_t weights [N_WGT];
  int   expected [N_RES];
  acc_t received [$];
  int   credit_due [$];
  int   outstanding;
  int   error_count;
  int   check_count;
  bit   timed_out;

  conv_layer_top i_conv_layer_top (
    .clk          (clk),
    .reset        (reset),
    .weight_valid (weight_valid),
    .weight_in    (weight_in),
    .pxl_valid    (pxl_valid),
    .pxl_in       (pxl_in),
    .out_credit   (out_credit),
    .in_ready     (in_ready),
    .out_valid    (out_valid),
    .out_data     (out_data)
  );

  always #5 clk = ~clk;

  task automatic check_condition(bit ok, string what);
    check_count++;
    assert (ok) else begin
      error_count++;
      $display("** Error at %0t: %s", $time, what);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus and reference model
  //////////////////////////////////////////////////

  function automatic pix_t make_pixel(int mode, int ic, int r, int c);
    case (mode)
      PIX_ONES: return pix_t'(1);
      PIX_RAMP: return pix_t'(ic * PLANE + r * `CONV_IMG_W + c - PLANE);
      default:  return pix_t'($urandom);
    endcase
  endfunction

  // Centre mode passes input channel oc straight through
  function automatic wgt_t make_weight(int mode, int oc, int ic, int kr, int kc);
    case (mode)
      WGT_CENTRE: return (oc == ic && kr == K / 2 && kc == K / 2) ? wgt_t'(1) : wgt_t'(0);
      WGT_ONES:   return wgt_t'(1);
      default:    return wgt_t'($urandom);
    endcase
  endfunction

  task automatic fill_inputs(int pix_mode, int wgt_mode, bit reload);
    for (int ic = 0; ic < `CONV_CH_IN; ic++)
      for (int r = 0; r < `CONV_IMG_H; r++)
        for (int c = 0; c < `CONV_IMG_W; c++)
          frame[ic * PLANE + r * `CONV_IMG_W + c] = make_pixel(pix_mode, ic, r, c);
    if (reload) begin
      for (int oc = 0; oc < `CONV_CH_OUT; oc++)
        for (int ic = 0; ic < `CONV_CH_IN; ic++)
          for (int kr = 0; kr < K; kr++)
            for (int kc = 0; kc < K; kc++)
              weights[((oc * `CONV_CH_IN + ic) * K + kr) * K + kc] =
                make_weight(wgt_mode, oc, ic, kr, kc);
    end
  endtask

  // Valid 3x3 convolution summed over the input channels
  task automatic compute_expected();
    int sum;
    for (int oc = 0; oc < `CONV_CH_OUT; oc++) begin
      for (int r = 0; r < OUT_H; r++) begin
        for (int c = 0; c < `CONV_OUT_W; c++) begin
          sum = 0;
          for (int ic = 0; ic < `CONV_CH_IN; ic++)
            for (int kr = 0; kr < K; kr++)
              for (int kc = 0; kc < K; kc++)
                sum += int'(frame[ic * PLANE + (r + kr) * `CONV_IMG_W + c + kc]) *
                       int'(weights[((oc * `CONV_CH_IN + ic) * K + kr) * K + kc]);
          expected[oc * `CONV_OUT_PIXELS + r * `CONV_OUT_W + c] = sum;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////

  task automatic wait_ready();
    int n;
    n = 0;
    while (!in_ready && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!in_ready) begin
      $display("Timeout: in_ready stayed low for %0d cycles at %0t", TIMEOUT, $time);
      error_count++;
      timed_out = 1'b1;
    end
  endtask

  task automatic load_weights();
    for (int i = 0; i < N_WGT; i++) begin
      @(posedge clk);
      #1;
      weight_valid = 1'b1;
      weight_in    = weights[i];
    end
    @(posedge clk);
    #1;
    weight_valid = 1'b0;
  endtask

  // Last pixel stays on the bus; the consumer loop takes over next cycle
  task automatic load_frame();
    for (int i = 0; i < N_PIX; i++) begin
      @(posedge clk);
      #1;
      pxl_valid = 1'b1;
      pxl_in    = frame[i];
    end
  endtask

  // Consumer with credit return, plus noise on the inputs while in_ready is low
  task automatic serve_outputs(int delay);
    int n;
    int low_cycles;
    bit rose;
    n          = 0;
    low_cycles = 0;
    rose       = 1'b0;
    received.delete();
    while ((received.size() < N_RES || credit_due.size() > 0) && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      if (n == 0) begin
        check_condition(!in_ready, "in_ready still high after the last pixel");
      end
      if (in_ready) begin
        rose         = 1'b1;
        pxl_valid    = 1'b0;
        weight_valid = 1'b0;
      end else begin
        check_condition(!rose, "in_ready fell again before the frame was done");
        low_cycles++;
        pxl_valid    = 1'($urandom);
        pxl_in       = pix_t'($urandom);
        weight_valid = 1'($urandom);
        weight_in    = wgt_t'($urandom);
      end
      if (out_valid) begin
        received.push_back(out_data);
        outstanding++;
        check_condition(outstanding <= `CONV_OUT_CREDITS,
                        $sformatf("%0d results outstanding without a credit", outstanding));
        credit_due.push_back(n + delay);
      end
      out_credit = 1'b0;
      if (credit_due.size() > 0 && credit_due[0] <= n) begin
        void'(credit_due.pop_front());
        out_credit = 1'b1;
        outstanding--;
      end
      n++;
    end
    // Last credit pulse still has to reach the queue
    @(posedge clk);
    #1;
    pxl_valid    = 1'b0;
    weight_valid = 1'b0;
    out_credit   = 1'b0;
    if (n >= TIMEOUT) begin
      $display("Timeout: got %0d of %0d results with %0d credits unreturned at %0t",
               received.size(), N_RES, credit_due.size(), $time);
      error_count++;
      timed_out = 1'b1;
    end else begin
      check_condition(low_cycles >= `CONV_CH_OUT * N_PIX,
                      $sformatf("in_ready low for only %0d cycles", low_cycles));
    end
  endtask

  task automatic compare_results(int row);
    check_condition(received.size() == N_RES,
                    $sformatf("row %0d gave %0d results, expected %0d",
                              row, received.size(), N_RES));
    for (int i = 0; i < N_RES && i < received.size(); i++) begin
      check_condition(received[i] == acc_t'(expected[i]),
                      $sformatf("row %0d result %0d is %0d, expected %0d",
                                row, i, received[i], expected[i]));
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    weight_valid = 1'b0;
    weight_in    = '0;
    pxl_valid    = 1'b0;
    pxl_in       = '0;
    out_credit   = 1'b0;
    outstanding  = 0;
    error_count  = 0;
    check_count  = 0;
    timed_out    = 1'b0;
    void'($urandom(32'h0301b86a));
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    check_condition(in_ready, "in_ready low after reset");
    check_condition(!out_valid, "out_valid high after reset");
    for (int row = 0; row < N_ROWS && !timed_out; row++) begin
      fill_inputs(pix_mode_tab[row], wgt_mode_tab[row], reload_tab[row]);
      compute_expected();
      wait_ready();
      if (!timed_out) begin
        if (reload_tab[row]) begin
          load_weights();
        end
        load_frame();
        serve_outputs(delay_tab[row]);
        if (!timed_out) begin
          compare_results(row);
        end
      end
    end
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+rtl
rtl/conv_pkg.sv
rtl/conv_loop_reader.sv
rtl/conv_window_engine.sv
rtl/conv_channel_accumulator.sv
rtl/conv_output_queue.sv
rtl/conv_layer_top.sv
test/conv_layer_properties.sv
test/conv_layer_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := conv_layer_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed
FAIL_MSG  := Testbench failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation did not pass"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
